// ==== logic/acqController.sv ====
`timescale 1ns/10ps

module acqController import hostPkg::*; (
    input  logic    Clk,
    input  logic    rstN,
    input  acqTimeT acqTime,
    input  logic    acqStart,
    input  logic    endReadout,
    output logic    startAcq,
    output logic    startReadout,
    output logic    readoutActive,
    output logic    acqBusy
);
    typedef enum logic [1:0] {IDLE, ACQUIRE, REQUEST, READOUT} stateT;

    stateT   state;
    acqTimeT winCnt;   // Cycles left in the window minus one

    assign readoutActive = (state == READOUT);
    assign acqBusy       = (state != IDLE);

    //////////////////////////////
    // Sequencer
    //////////////////////////////
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state        <= IDLE;
            winCnt       <= '0;
            startAcq     <= 1'b0;
            startReadout <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (acqStart) begin
                        state    <= ACQUIRE;
                        startAcq <= 1'b1;
                        // Zero window runs as one cycle
                        winCnt   <= (acqTime == '0) ? '0 : acqTime - 1'b1;
                    end
                end
                ACQUIRE: begin
                    if (winCnt == '0) begin
                        startAcq     <= 1'b0;
                        startReadout <= 1'b1;   // Right after the window
                        state        <= REQUEST;
                    end else begin
                        winCnt <= winCnt - 1'b1;
                    end
                end
                REQUEST: begin
                    startReadout <= 1'b0;
                    state        <= READOUT;
                end
                READOUT: begin
                    if (endReadout)
                        state <= IDLE;   // Chip finished its RAM
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Readout request comes only in the cycle after the window closes
    assert property (@(posedge Clk) disable iff (!rstN)
        startReadout |-> !startAcq && $past(startAcq));

endmodule

// ==== logic/apbRegFile.sv ====
`timescale 1ns/10ps
`include "microroc_config.svh"

module apbRegFile import microrocPkg::*, hostPkg::*; (
    input  logic                       Clk,
    input  logic                       rstN,
    input  logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [31:0]                pwdata,
    input  logic                       loaderBusy,
    input  logic                       configDone,
    input  logic                       acqBusy,
    input  logic [7:0]                 overflowCount,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    output scFrameT                    scFrame,
    output readRegT                    readReg,
    output logic                       scOrRead,
    output logic                       loadStart,
    output acqTimeT                    acqTime,
    output logic                       acqStart,
    output logic                       fifoClear
);
    logic access;     // Access phase of a transfer
    logic addrValid;
    logic wrAccess;

    assign access   = psel && penable;
    assign wrAccess = access && pwrite && addrValid;
    assign pready   = 1'b1;                 // Zero wait states
    assign pslverr  = access && !addrValid;

    always_comb begin
        case (paddr)
            CTRL, DAC0, DAC1, DAC2, HEADER, CTEST_LO, CTEST_HI,
            READREG_LO, READREG_HI, ACQTIME, STATUS: addrValid = 1'b1;
            default:                                 addrValid = 1'b0;
        endcase
    end

    //////////////////////////////
    // Write side
    //////////////////////////////
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            scFrame   <= '0;
            readReg   <= '0;
            acqTime   <= '0;
            scOrRead  <= 1'b0;
            loadStart <= 1'b0;
            acqStart  <= 1'b0;
            fifoClear <= 1'b0;
        end else begin
            loadStart <= 1'b0;   // Pulses last one cycle
            acqStart  <= 1'b0;
            fifoClear <= 1'b0;
            if (wrAccess) begin
                case (paddr)
                    CTRL: begin
                        scOrRead  <= pwdata[CTRL_SC_OR_READ];
                        loadStart <= pwdata[CTRL_START_LOAD];
                        acqStart  <= pwdata[CTRL_ACQ_START];
                        fifoClear <= pwdata[CTRL_FIFO_CLEAR];
                    end
                    DAC0:       scFrame.dac0   <= pwdata[`DAC_WIDTH-1:0];
                    DAC1:       scFrame.dac1   <= pwdata[`DAC_WIDTH-1:0];
                    DAC2:       scFrame.dac2   <= pwdata[`DAC_WIDTH-1:0];
                    HEADER:     scFrame.header <= pwdata[`HEADER_WIDTH-1:0];
                    CTEST_LO:   scFrame.ctest[31:0] <= pwdata;
                    CTEST_HI:   scFrame.ctest[`CTEST_WIDTH-1:32] <= pwdata;
                    READREG_LO: readReg[31:0] <= pwdata;
                    READREG_HI: readReg[`READ_REG_WIDTH-1:32] <= pwdata;
                    ACQTIME:    acqTime <= pwdata[$bits(acqTimeT)-1:0];
                    default:    ;  // STATUS ignores writes
                endcase
            end
        end
    end

    // Read mux, pulse bits of CTRL read back as zero
    always_comb begin
        prdata = '0;
        case (paddr)
            CTRL:       prdata[CTRL_SC_OR_READ] = scOrRead;
            DAC0:       prdata[`DAC_WIDTH-1:0] = scFrame.dac0;
            DAC1:       prdata[`DAC_WIDTH-1:0] = scFrame.dac1;
            DAC2:       prdata[`DAC_WIDTH-1:0] = scFrame.dac2;
            HEADER:     prdata[`HEADER_WIDTH-1:0] = scFrame.header;
            CTEST_LO:   prdata = scFrame.ctest[31:0];
            CTEST_HI:   prdata = scFrame.ctest[`CTEST_WIDTH-1:32];
            READREG_LO: prdata = readReg[31:0];
            READREG_HI: prdata = readReg[`READ_REG_WIDTH-1:32];
            ACQTIME:    prdata[$bits(acqTimeT)-1:0] = acqTime;
            STATUS:     prdata = {16'b0, overflowCount, 5'b0, acqBusy, configDone, loaderBusy};
            default:    prdata = '0;
        endcase
    end

    // Error only in an access phase that follows its setup phase
    assert property (@(posedge Clk) disable iff (!rstN)
        pslverr |-> psel && penable && $past(psel && !penable));

endmodule

// ==== logic/daqTop.sv ====
`timescale 1ns/10ps
`include "microroc_config.svh"

module daqTop import microrocPkg::*, hostPkg::*; (
    input  logic                       Clk,
    input  logic                       rstN,
    // APB host
    input  logic [`APB_ADDR_WIDTH-1:0] paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       pready,
    output logic                       pslverr,
    // MICROROC pins
    output logic                       select,
    output logic                       srRstb,
    output logic                       srCk,
    output logic                       srIn,
    output logic                       startAcq,
    output logic                       startReadout,
    input  logic                       endReadout,
    input  logic                       doutB,
    input  logic                       transmitOnB,
    // Data reader
    input  logic                       dataRdEn,
    output dataWordT                   dataOut,
    output logic                       dataEmpty
);
    scFrameT    scFrame;
    readRegT    readReg;
    acqTimeT    acqTime;
    logic       scOrRead, loadStart, acqStart, fifoClear;
    logic       loaderBusy, configDone, acqBusy, readoutActive;
    logic       wrEn;
    dataWordT   wrData;
    logic [7:0] overflowCount;

    //////////////////////////////
    // Host registers and loader
    //////////////////////////////
    apbRegFile uRegs (.Clk, .rstN, .paddr, .psel, .penable, .pwrite, .pwdata,
        .loaderBusy, .configDone, .acqBusy, .overflowCount, .prdata, .pready, .pslverr,
        .scFrame, .readReg, .scOrRead, .loadStart, .acqTime, .acqStart, .fifoClear);

    scLoader uLoader (.Clk, .rstN, .scFrame, .readReg, .scOrRead, .loadStart,
        .select, .srRstb, .srCk, .srIn, .loaderBusy, .configDone);

    //////////////////////////////
    // Acquisition and readout
    //////////////////////////////
    acqController uAcq (.Clk, .rstN, .acqTime, .acqStart, .endReadout,
        .startAcq, .startReadout, .readoutActive, .acqBusy);

    ramDeserializer uDeser (.Clk, .rstN, .readoutActive, .doutB, .transmitOnB,
        .wrEn, .wrData);

    dataFifo uFifo (.Clk, .rstN, .wrEn, .wrData, .dataRdEn, .fifoClear,
        .dataOut, .dataEmpty, .overflowCount);

endmodule

// ==== logic/dataFifo.sv ====
`timescale 1ns/10ps
`include "microroc_config.svh"

module dataFifo import microrocPkg::*; (
    input  logic     Clk,
    input  logic     rstN,
    input  logic     wrEn,
    input  dataWordT wrData,
    input  logic     dataRdEn,
    input  logic     fifoClear,
    output dataWordT dataOut,
    output logic     dataEmpty,
    output logic [7:0] overflowCount
);
    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    dataWordT         mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] fillCnt;
    logic             full;
    logic             doWrite;
    logic             doRead;

    assign full      = (fillCnt == CNT_W'(DEPTH));
    assign dataEmpty = (fillCnt == '0);
    assign dataOut   = mem[rdPtr];            // Head word, no read latency
    assign doWrite   = wrEn && !full;
    assign doRead    = dataRdEn && !dataEmpty;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fillCnt <= '0;
            overflowCount <= '0;
        end else if (fifoClear) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fillCnt <= '0;
            overflowCount <= '0;
        end else begin
            if (doWrite) wrPtr <= nextPtr(wrPtr);
            if (doRead)  rdPtr <= nextPtr(rdPtr);
            if (doWrite && !doRead)      fillCnt <= fillCnt + 1'b1;
            else if (doRead && !doWrite) fillCnt <= fillCnt - 1'b1;
            if (wrEn && full && overflowCount != 8'hFF)
                overflowCount <= overflowCount + 1'b1;   // Saturates at 255
        end
    end

    always_ff @(posedge Clk) begin
        if (doWrite && !fifoClear) mem[wrPtr] <= wrData;
    end

    assert property (@(posedge Clk) disable iff (!rstN) fillCnt <= CNT_W'(DEPTH));

endmodule

// ==== logic/hostPkg.sv ====
`include "microroc_config.svh"

package hostPkg;

    // Register map, byte addresses on word boundaries
    typedef enum logic [`APB_ADDR_WIDTH-1:0] {
        CTRL       = 8'h00,
        DAC0       = 8'h04,
        DAC1       = 8'h08,
        DAC2       = 8'h0C,
        HEADER     = 8'h10,
        CTEST_LO   = 8'h14,
        CTEST_HI   = 8'h18,
        READREG_LO = 8'h1C,
        READREG_HI = 8'h20,
        ACQTIME    = 8'h24,
        STATUS     = 8'h28   // Read only
    } regAddrT;

    // CTRL bits
    localparam int CTRL_START_LOAD  = 0;  // Pulse
    localparam int CTRL_SC_OR_READ  = 1;  // Level, 1 selects slow control
    localparam int CTRL_ACQ_START   = 2;  // Pulse
    localparam int CTRL_FIFO_CLEAR  = 3;  // Pulse

    typedef logic [15:0] acqTimeT;       // Acquisition window in clocks

endpackage

// ==== logic/microrocPkg.sv ====
`include "microroc_config.svh"

package microrocPkg;

    //////////////////////////////
    // Chip level field types
    //////////////////////////////
    typedef logic [`DAC_WIDTH-1:0]      dacCodeT;   // Threshold code
    typedef logic [`HEADER_WIDTH-1:0]   headerT;    // Chip id in data
    typedef logic [`CTEST_WIDTH-1:0]    ctestT;     // Test cap enables
    typedef logic [`READ_REG_WIDTH-1:0] readRegT;   // Channel probe select
    typedef logic [`WORD_WIDTH-1:0]     dataWordT;  // Packed RAM data

    // Slow-control frame
    // Top member leaves the FPGA first, each member MSB first
    typedef struct packed {
        headerT  header;
        dacCodeT dac0;
        dacCodeT dac1;
        dacCodeT dac2;
        ctestT   ctest;
    } scFrameT;

endpackage

// ==== logic/microroc_config.svh ====
`ifndef MICROROC_CONFIG_SVH
`define MICROROC_CONFIG_SVH

// ASIC side field widths
`define DAC_WIDTH        10
`define HEADER_WIDTH     8
`define CTEST_WIDTH      64   // One enable per channel
`define READ_REG_WIDTH   64
`define SC_FRAME_LEN     102  // Header plus three DACs plus ctest

// Readout path
`define WORD_WIDTH       16
`define FIFO_DEPTH       16

// Loader timing and host bus
`define SR_RESET_CYCLES  4    // Chain reset low time
`define APB_ADDR_WIDTH   8

`endif

// ==== logic/ramDeserializer.sv ====
`timescale 1ns/10ps
`include "microroc_config.svh"

module ramDeserializer import microrocPkg::*; (
    input  logic     Clk,
    input  logic     rstN,
    input  logic     readoutActive,
    input  logic     doutB,        // Active low serial data
    input  logic     transmitOnB,  // Low while chip sends
    output logic     wrEn,
    output dataWordT wrData
);
    localparam int CNT_W = $clog2(`WORD_WIDTH);

    logic [CNT_W-1:0] bitCnt;
    logic             bitValid;
    logic             lastBit;
    dataWordT         shiftReg;
    dataWordT         nextWord;

    assign bitValid = readoutActive && !transmitOnB;
    assign lastBit  = bitValid && (bitCnt == CNT_W'(`WORD_WIDTH - 1));
    assign nextWord = {shiftReg[`WORD_WIDTH-2:0], ~doutB};  // First bit ends up in MSB

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            bitCnt <= '0;
            wrEn   <= 1'b0;
        end else begin
            wrEn <= lastBit;
            if (!readoutActive)
                bitCnt <= '0;          // Drop partial word, fresh start next readout
            else if (bitValid)
                bitCnt <= bitCnt + 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (bitValid) shiftReg <= nextWord;
        if (lastBit)  wrData   <= nextWord;
    end

endmodule

// ==== logic/scLoader.sv ====
`timescale 1ns/10ps
`include "microroc_config.svh"

module scLoader import microrocPkg::*; (
    input  logic    Clk,
    input  logic    rstN,
    input  scFrameT scFrame,
    input  readRegT readReg,
    input  logic    scOrRead,
    input  logic    loadStart,
    output logic    select,      // 1 slow control, 0 read register
    output logic    srRstb,
    output logic    srCk,
    output logic    srIn,
    output logic    loaderBusy,
    output logic    configDone
);
    localparam int LEN   = `SC_FRAME_LEN;
    localparam int CNT_W = $clog2(`SC_FRAME_LEN + 1);
    localparam int RST_W = $clog2(`SR_RESET_CYCLES + 1);

    typedef enum logic [1:0] {IDLE, CHAIN_RST, SHIFT} stateT;

    stateT            state;
    logic [LEN-1:0]   shiftReg;  // Current bit sits at the MSB
    logic [CNT_W-1:0] bitCnt;    // Bits still to send
    logic [RST_W-1:0] rstCnt;

    assign loaderBusy = (state != IDLE);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state      <= IDLE;
            select     <= 1'b0;
            srRstb     <= 1'b1;
            srCk       <= 1'b0;
            srIn       <= 1'b0;
            configDone <= 1'b0;
            bitCnt     <= '0;
            rstCnt     <= '0;
        end else begin
            case (state)
                IDLE: if (loadStart) begin
                    state      <= CHAIN_RST;
                    select     <= scOrRead;   // Held for the whole load
                    srRstb     <= 1'b0;
                    configDone <= 1'b0;
                    rstCnt     <= RST_W'(`SR_RESET_CYCLES - 1);
                    bitCnt     <= scOrRead ? CNT_W'(`SC_FRAME_LEN) : CNT_W'(`READ_REG_WIDTH);
                end
                CHAIN_RST: begin
                    if (rstCnt == '0) begin
                        srRstb <= 1'b1;
                        srIn   <= shiftReg[LEN-1];   // First bit, clock still low
                        state  <= SHIFT;
                    end else begin
                        rstCnt <= rstCnt - 1'b1;
                    end
                end
                SHIFT: begin
                    if (!srCk) begin
                        srCk <= 1'b1;                // Chip samples on this rise
                    end else begin
                        srCk <= 1'b0;
                        if (bitCnt == CNT_W'(1)) begin
                            configDone <= 1'b1;
                            state      <= IDLE;
                        end else begin
                            bitCnt <= bitCnt - 1'b1;
                            srIn   <= shiftReg[LEN-2];
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Payload, read register left aligned so both go MSB first
    always_ff @(posedge Clk) begin
        if (state == IDLE && loadStart)
            shiftReg <= scOrRead ? scFrame : {readReg, {(LEN - `READ_REG_WIDTH){1'b0}}};
        else if (state == SHIFT && srCk)
            shiftReg <= shiftReg << 1;
    end

    assert property (@(posedge Clk) disable iff (!rstN) $rose(srCk) |-> loaderBusy);
    assert property (@(posedge Clk) disable iff (!rstN) srCk |-> $stable(srIn));

endmodule

// ==== sim/daqTb.sv ====
`timescale 1ns/10ps
`include "microroc_config.svh"

module daqTb import microrocPkg::*, hostPkg::*; ();

    // Readout scenarios
    localparam int WIN_A      = 5;
    localparam int BITS_A     = 53;                       // Three words plus a partial
    localparam int WIN_B      = 0;                        // Runs as one cycle
    localparam int BITS_B     = 40;
    localparam int EXCESS     = 3;
    localparam int BITS_OVER  = `WORD_WIDTH * (`FIFO_DEPTH + EXCESS);
    localparam int BITS_SMALL = 32;
    localparam int TOTAL_BITS = BITS_A + BITS_B + BITS_OVER + BITS_SMALL;
    // Watchdog budget in clocks
    localparam int APB_CYCLES  = 3;
    localparam int LOAD_CYCLES = `SR_RESET_CYCLES + 2 * `SC_FRAME_LEN + 40 * APB_CYCLES;
    localparam int WATCHDOG_CYCLES = 60 * APB_CYCLES + 2 * LOAD_CYCLES
                                   + 2 * TOTAL_BITS + 4 * (20 + 10 * APB_CYCLES)
                                   + 4 * `FIFO_DEPTH + 500;   // Margin

    logic Clk, rstN;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic psel, penable, pwrite, pready, pslverr;
    logic [31:0] pwdata, prdata;
    logic select, srRstb, srCk, srIn, startAcq, startReadout;
    logic endReadout, doutB, transmitOnB, dataRdEn, dataEmpty;
    dataWordT dataOut;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] rng = 32'd29;     // xorshift state
    logic        lastErr;          // pslverr of the latest APB access
    logic        expSelect;
    int          readoutBits;
    logic        readoutDone;
    bit          capBits[$];       // srIn at each srCk rise
    bit          expBits[$];       // Bits the deserializer should take

    daqTop dut (.Clk, .rstN, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .pslverr, .select, .srRstb, .srCk, .srIn, .startAcq, .startReadout, .endReadout,
        .doutB, .transmitOnB, .dataRdEn, .dataOut, .dataEmpty);

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;   // 10 MHz
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compareValue(input string name, input logic [63:0] expVal,
                                input logic [63:0] actVal);
        checks++;
        assert (actVal === expVal) else begin
            errors++;
            $display("Mismatch %s: expected 0x%0h, actual 0x%0h", name, expVal, actVal);
        end
    endtask

    task automatic requireTrue(input logic cond, input string msg);
        checks++;
        assert (cond === 1'b1) else begin
            errors++;
            $display("Error: %s", msg);
        end
    endtask

    // Setup phase, access phase, sample before the closing edge
    task automatic apbWrite(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
        @(posedge Clk);
        paddr   <= addr;
        pwrite  <= 1'b1;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge Clk);
        penable <= 1'b1;
        @(negedge Clk);
        lastErr = pslverr;
        requireTrue(pready, "pready low in an access phase");
        @(posedge Clk);                // Write lands here
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apbRead(input logic [`APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        @(posedge Clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge Clk);
        penable <= 1'b1;
        @(negedge Clk);
        data    = prdata;
        lastErr = pslverr;
        @(posedge Clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic popWord(output dataWordT word, output bit ok);
        @(negedge Clk);
        ok   = !dataEmpty;
        word = dataOut;
        if (ok) begin
            @(posedge Clk) dataRdEn <= 1'b1;
            @(posedge Clk) dataRdEn <= 1'b0;   // Popped at this edge
        end
    endtask

    // Pops count words, expected packed MSB first from expBits
    task automatic drainWords(input int count, input string name);
        dataWordT expWord;
        dataWordT word;
        bit       ok;
        for (int k = 0; k < count; k++) begin
            expWord = '0;
            for (int b = 0; b < `WORD_WIDTH; b++)
                expWord = {expWord[`WORD_WIDTH-2:0], expBits[k*`WORD_WIDTH + b]};
            popWord(word, ok);
            requireTrue(ok, "FIFO ran empty before all expected words were read");
            compareValue($sformatf("%s word %0d", name, k), expWord, word);
        end
        @(negedge Clk);
        compareValue({name, " empty after drain"}, 1, dataEmpty);
    endtask

    task automatic loadChain(input bit scSel, input logic [`SC_FRAME_LEN-1:0] expVec,
                             input int len, input string name);
        logic [31:0] rd;
        int          polls;
        capBits.delete();
        expSelect = scSel;
        apbWrite(CTRL, (32'(scSel) << CTRL_SC_OR_READ) | (32'd1 << CTRL_START_LOAD));
        for (polls = 0; polls < 200; polls++) begin
            apbRead(STATUS, rd);
            if (rd[1] && !rd[0])
                break;                 // configDone and not busy
        end
        requireTrue(polls < 200, "chain load never reported configDone");
        compareValue({name, " bit count"}, len, capBits.size());
        for (int i = 0; i < len && i < capBits.size(); i++)
            compareValue($sformatf("%s bit %0d", name, i), expVec[len-1-i], capBits[i]);
        compareValue({name, " select after load"}, scSel, select);
    endtask

    task automatic runAcquisition(input int winLen, input int nBits, input bit drain,
                                  input string name);
        int          width;
        int          polls;
        logic [31:0] rd;
        readoutBits = nBits;
        readoutDone = 1'b0;
        expBits.delete();
        apbWrite(ACQTIME, winLen);
        apbWrite(CTRL, 32'd1 << CTRL_ACQ_START);
        polls = 0;
        @(negedge Clk);
        while (!startAcq && polls < 10) begin
            @(negedge Clk);
            polls++;
        end
        requireTrue(startAcq, "startAcq never rose after acqStart");
        width = 0;
        while (startAcq && width < winLen + 10) begin
            width++;
            @(negedge Clk);
        end
        compareValue({name, " window"}, (winLen == 0) ? 1 : winLen, width);
        compareValue({name, " startReadout"}, 1, startReadout);
        @(negedge Clk);
        compareValue({name, " startReadout width"}, 0, startReadout);
        polls = 0;
        while (!readoutDone && polls < 3 * nBits + 20) begin
            @(negedge Clk);
            polls++;
        end
        requireTrue(readoutDone, "readout did not end");
        apbRead(STATUS, rd);
        compareValue({name, " acqBusy"}, 0, rd[2]);
        if (drain)
            drainWords(nBits / `WORD_WIDTH, name);
    endtask

    //////////////////////////////
    // ASIC model
    //////////////////////////////
    always @(posedge srCk) begin
        capBits.push_back(srIn);
        requireTrue(select === expSelect, "select changed during a chain load");
        requireTrue(srRstb, "srCk pulsed while the chain reset was low");
    end

    // Answers startReadout, a pause every tenth bit
    always begin
        @(negedge Clk);
        if (startReadout) begin
            @(posedge Clk);
            for (int i = 0; i < readoutBits; i++) begin
                if (i % 10 == 9) begin
                    transmitOnB <= 1'b1;
                    doutB       <= 1'b0;   // Must be ignored
                    @(posedge Clk);
                end
                rng = xorshift32(rng);
                doutB       <= rng[0];
                transmitOnB <= 1'b0;
                expBits.push_back(~rng[0]);
                @(posedge Clk);
            end
            transmitOnB <= 1'b1;
            doutB       <= 1'b1;
            endReadout  <= 1'b1;
            @(posedge Clk);
            endReadout  <= 1'b0;
            readoutDone = 1'b1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge Clk);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        regAddrT     regList [9];
        logic [31:0] fieldMask [9];
        logic [31:0] shadow [9];
        logic [31:0] rd;
        logic [`SC_FRAME_LEN-1:0] frame;
        rstN = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        endReadout = 1'b0;
        doutB = 1'b1;
        transmitOnB = 1'b1;   // Chip silent
        dataRdEn = 1'b0;
        expSelect = 1'b0;
        readoutBits = 0;
        readoutDone = 1'b0;
        repeat (2) @(posedge Clk);
        rstN <= 1'b1;
        @(negedge Clk);
        compareValue("reset srRstb", 1, srRstb);
        compareValue("reset srCk", 0, srCk);
        compareValue("reset select", 0, select);
        compareValue("reset startAcq", 0, startAcq);
        compareValue("reset startReadout", 0, startReadout);
        compareValue("reset dataEmpty", 1, dataEmpty);

        // Register access, readback masked to field width
        regList   = '{DAC0, DAC1, DAC2, HEADER, CTEST_LO, CTEST_HI,
                      READREG_LO, READREG_HI, ACQTIME};
        fieldMask = '{32'h3FF, 32'h3FF, 32'h3FF, 32'hFF, '1, '1, '1, '1, 32'hFFFF};
        for (int i = 0; i < 9; i++) begin
            rng = xorshift32(rng);
            shadow[i] = rng & fieldMask[i];
            apbWrite(regList[i], rng);
            compareValue($sformatf("regs write pslverr %0d", i), 0, lastErr);
        end
        for (int i = 0; i < 9; i++) begin
            apbRead(regList[i], rd);
            compareValue($sformatf("regs readback %0d", i), shadow[i], rd);
        end
        apbWrite(CTRL, 32'd1 << CTRL_SC_OR_READ);
        apbRead(CTRL, rd);
        compareValue("regs CTRL level", 32'h2, rd);
        apbWrite(CTRL, 32'd1 << CTRL_FIFO_CLEAR);
        apbRead(CTRL, rd);
        compareValue("regs CTRL pulse bits", 32'h0, rd);
        apbWrite(STATUS, '1);
        apbRead(STATUS, rd);
        compareValue("regs STATUS idle", 32'h0, rd);
        apbWrite(8'h2C, 32'hFFFF_FFFF);
        compareValue("regs unlisted write pslverr", 1, lastErr);
        apbRead(8'h03, rd);
        compareValue("regs unlisted read pslverr", 1, lastErr);
        apbRead(DAC0, rd);
        compareValue("regs DAC0 after bad write", shadow[0], rd);

        // Chain loads, frame order header, DAC0..2, ctest
        frame = {shadow[3][7:0], shadow[0][9:0], shadow[1][9:0], shadow[2][9:0],
                 shadow[5], shadow[4]};
        loadChain(1'b1, frame, `SC_FRAME_LEN, "slow control");
        loadChain(1'b0, `SC_FRAME_LEN'({shadow[7], shadow[6]}), `READ_REG_WIDTH,
                  "read register");

        // Acquisition windows and readout words
        runAcquisition(WIN_A, BITS_A, 1'b1, "acq A");
        runAcquisition(WIN_B, BITS_B, 1'b1, "acq B");

        // Back-pressure, then clear
        runAcquisition(2, BITS_OVER, 1'b0, "overflow");
        apbRead(STATUS, rd);
        compareValue("overflow count", EXCESS, rd[15:8]);
        drainWords(`FIFO_DEPTH, "overflow");
        runAcquisition(2, BITS_SMALL, 1'b0, "refill");
        @(negedge Clk);
        compareValue("refill not empty", 0, dataEmpty);
        apbWrite(CTRL, 32'd1 << CTRL_FIFO_CLEAR);
        repeat (2) @(negedge Clk);   // Pulse cycle, then the FIFO clears
        compareValue("clear dataEmpty", 1, dataEmpty);
        apbRead(STATUS, rd);
        compareValue("clear overflow count", 0, rd[15:8]);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+logic
logic/microrocPkg.sv
logic/hostPkg.sv
logic/apbRegFile.sv
logic/scLoader.sv
logic/acqController.sv
logic/ramDeserializer.sv
logic/dataFifo.sv
logic/daqTop.sv
sim/daqTb.sv
